// File: hw/qdq_defines.svh
`ifndef QDQ_DEFINES_SVH
`define QDQ_DEFINES_SVH

// ----------------------------------------
// row geometry
// ----------------------------------------

// elements per row
`define QDQ_NUM_COL 4

// input and dequantized element width
`define QDQ_ELEM_W 16

// quantized element width
`define QDQ_Q_W 8

// right shift applied per row
`define QDQ_SHIFT_W 4

// ----------------------------------------
// storage
// ----------------------------------------

`define QDQ_NUM_ROW 8
`define QDQ_ROW_IDX_W 3

// input FIFO depth, also the initial output credit count
`define QDQ_FIFO_DEPTH 4

`endif

// File: hw/qdq_pkg.sv
`default_nettype none

`include "qdq_defines.svh"

package qdq_pkg;

	typedef enum logic {
		MAT_X = 1'b0,
		MAT_W = 1'b1
	} qdq_mat_e;

	typedef logic [`QDQ_SHIFT_W-1:0] qdq_shift_t;
	typedef logic [`QDQ_ROW_IDX_W-1:0] qdq_row_idx_t;

	// matrix select on top of the row index
	typedef logic [`QDQ_ROW_IDX_W:0] qdq_word_idx_t;

	typedef struct packed {
		logic [`QDQ_NUM_COL-1:0][`QDQ_ELEM_W-1:0] elem;
		logic last;
		qdq_row_idx_t row_idx;
	} qdq_in_row_t;

	// what one memory word holds
	typedef struct packed {
		logic [`QDQ_NUM_COL-1:0][`QDQ_Q_W-1:0] elem;
		qdq_shift_t shift;
	} qdq_q_word_t;

	typedef struct packed {
		qdq_q_word_t word;
		qdq_mat_e mat;
		qdq_row_idx_t row_idx;
		logic last;
	} qdq_q_row_t;

	typedef struct packed {
		qdq_word_idx_t idx;
		qdq_q_word_t word;
	} qdq_sram_wr_t;

	typedef struct packed {
		qdq_mat_e mat;
		qdq_row_idx_t row_idx;
	} qdq_rd_req_t;

	typedef struct packed {
		logic [`QDQ_NUM_COL-1:0][`QDQ_ELEM_W-1:0] elem;
		qdq_mat_e mat;
		qdq_row_idx_t row_idx;
	} qdq_out_row_t;

endpackage

`default_nettype wire

// File: hw/qdq_row_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "qdq_defines.svh"

module qdq_row_fifo
	import qdq_pkg::*;
#(
	parameter type T = qdq_in_row_t
) (
	input wire clk,
	input wire rstnn,

	// credit side
	input wire i_valid,
	input wire T i_data,
	output logic o_credit,

	// valid/ready side
	output logic o_valid,
	output T o_data,
	input wire i_ready
);

	localparam int DEPTH = `QDQ_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;

	// sender only pushes while holding a credit
	assign push = i_valid;
	assign pop = o_valid & i_ready;

	assign o_valid = (count != '0);
	assign o_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// slot freed, hand the credit back
			o_credit <= pop;
		end
	end

	// a credit only comes back a cycle after the pop, so never full on push
	a_no_push_full: assert property (@(posedge clk) disable iff (!rstnn)
		push |-> (count != (PTR_W+1)'(DEPTH)));

endmodule

`default_nettype wire

// File: hw/qdq_row_quantizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "qdq_defines.svh"

module qdq_row_quantizer
	import qdq_pkg::*;
#(
	parameter qdq_mat_e MAT = MAT_X
) (
	input wire clk,
	input wire rstnn,

	input wire i_valid,
	input wire qdq_in_row_t i_row,
	output logic o_ready,

	output logic o_valid,
	output qdq_q_row_t o_row,
	input wire i_ready
);

	localparam int MAX_SHIFT = `QDQ_ELEM_W - `QDQ_Q_W;

	logic en;
	logic s1_valid;
	qdq_in_row_t s1_row;
	qdq_shift_t s1_shift;
	qdq_q_word_t q_word;

	// smallest shift that brings every element into 8-bit range
	function automatic qdq_shift_t find_shift(input qdq_in_row_t row);
		qdq_shift_t s;
		logic signed [`QDQ_ELEM_W-1:0] v;
		logic fits;
		s = qdq_shift_t'(MAX_SHIFT);
		for (int k = MAX_SHIFT; k >= 0; k--) begin
			fits = 1'b1;
			for (int c = 0; c < `QDQ_NUM_COL; c++) begin
				v = $signed(row.elem[c]) >>> k;
				if (v > 16'sd127 || v < -16'sd128) begin
					fits = 1'b0;
				end
			end
			if (fits) begin
				s = qdq_shift_t'(k);
			end
		end
		return s;
	endfunction

	// both stages move together, a stalled output holds stage one too
	assign en = !o_valid || i_ready;
	assign o_ready = en;

	always_comb begin
		logic signed [`QDQ_ELEM_W-1:0] t;
		q_word.shift = s1_shift;
		for (int c = 0; c < `QDQ_NUM_COL; c++) begin
			t = $signed(s1_row.elem[c]) >>> s1_shift;
			q_word.elem[c] = t[`QDQ_Q_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			s1_valid <= 1'b0;
			o_valid <= 1'b0;
		end else if (en) begin
			s1_valid <= i_valid;
			o_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			s1_row <= i_row;
			s1_shift <= find_shift(i_row);
			o_row.word <= q_word;
			o_row.mat <= MAT;
			o_row.row_idx <= s1_row.row_idx;
			o_row.last <= s1_row.last;
		end
	end

	a_shift_range: assert property (@(posedge clk) disable iff (!rstnn)
		o_valid |-> (o_row.word.shift <= qdq_shift_t'(MAX_SHIFT)));

endmodule

`default_nettype wire

// File: hw/qdq_store_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "qdq_defines.svh"

module qdq_store_arbiter
	import qdq_pkg::*;
(
	input wire clk,
	input wire rstnn,

	input wire i_x_valid,
	input wire qdq_q_row_t i_x_row,
	output logic o_x_ready,

	input wire i_w_valid,
	input wire qdq_q_row_t i_w_row,
	output logic o_w_ready,

	output logic o_wr_en,
	output qdq_sram_wr_t o_wr,
	output logic [1:0] o_stored
);

	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_X,
		GRANT_W
	} grant_e;

	grant_e grant_q;
	grant_e grant;
	logic acc;
	qdq_q_row_t acc_row;
	logic wr_last;

	// ----------------------------------------
	// grant
	// ----------------------------------------

	// X wins when both show up with no grant held
	always_comb begin
		grant = grant_q;
		if (grant_q == GRANT_NONE) begin
			if (i_x_valid) begin
				grant = GRANT_X;
			end else if (i_w_valid) begin
				grant = GRANT_W;
			end
		end
	end

	assign o_x_ready = (grant == GRANT_X);
	assign o_w_ready = (grant == GRANT_W);

	assign acc = (i_x_valid & o_x_ready) | (i_w_valid & o_w_ready);
	assign acc_row = o_x_ready ? i_x_row : i_w_row;

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			grant_q <= GRANT_NONE;
		end else if (acc && acc_row.last) begin
			grant_q <= GRANT_NONE;
		end else begin
			grant_q <= grant;
		end
	end

	// ----------------------------------------
	// write port
	// ----------------------------------------

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			o_wr_en <= 1'b0;
			wr_last <= 1'b0;
			o_stored <= 2'b00;
		end else begin
			o_wr_en <= acc;
			wr_last <= acc & acc_row.last;
			// top index bit is the matrix
			o_stored[0] <= wr_last & (o_wr.idx[`QDQ_ROW_IDX_W] == MAT_X);
			o_stored[1] <= wr_last & (o_wr.idx[`QDQ_ROW_IDX_W] == MAT_W);
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			o_wr.idx <= {acc_row.mat, acc_row.row_idx};
			o_wr.word <= acc_row.word;
		end
	end

	a_one_ready: assert property (@(posedge clk) disable iff (!rstnn)
		!(o_x_ready && o_w_ready));

endmodule

`default_nettype wire

// File: hw/qdq_row_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "qdq_defines.svh"

module qdq_row_sram
	import qdq_pkg::*;
(
	input wire clk,
	input wire rstnn,

	input wire i_wr_en,
	input wire qdq_sram_wr_t i_wr,

	input wire i_rd_en,
	input wire qdq_word_idx_t i_rd_idx,
	output logic o_rd_valid,
	output qdq_q_word_t o_rd_word
);

	// X rows in the lower half, W rows in the upper half
	localparam int NUM_WORD = 2 * `QDQ_NUM_ROW;

	qdq_q_word_t mem [NUM_WORD];

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr.idx] <= i_wr.word;
		end
		if (i_rd_en) begin
			o_rd_word <= mem[i_rd_idx];
		end
	end

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			o_rd_valid <= 1'b0;
		end else begin
			o_rd_valid <= i_rd_en;
		end
	end

endmodule

`default_nettype wire

// File: hw/qdq_row_dequantizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "qdq_defines.svh"

module qdq_row_dequantizer
	import qdq_pkg::*;
(
	input wire clk,
	input wire rstnn,

	input wire i_rq_valid,
	input wire qdq_rd_req_t i_rq,
	output logic o_rq_ready,

	output logic o_rd_en,
	output qdq_word_idx_t o_rd_idx,
	input wire i_rd_valid,
	input wire qdq_q_word_t i_rd_word,

	input wire i_out_credit,
	output logic o_out_valid,
	output qdq_out_row_t o_out_row
);

	localparam int DEPTH = `QDQ_FIFO_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CNT_W-1:0] credit_cnt;
	logic pop;
	qdq_rd_req_t rq_q;
	qdq_out_row_t deq;

	// credit is spent at pop, so rows in flight are already counted
	assign o_rq_ready = (credit_cnt != '0);
	assign pop = i_rq_valid & o_rq_ready;

	assign o_rd_en = pop;
	assign o_rd_idx = {i_rq.mat, i_rq.row_idx};

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			credit_cnt <= CNT_W'(DEPTH);
		end else begin
			case ({pop, i_out_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// sign extend then scale back up
	always_comb begin
		logic signed [`QDQ_ELEM_W-1:0] ext;
		deq.mat = rq_q.mat;
		deq.row_idx = rq_q.row_idx;
		for (int c = 0; c < `QDQ_NUM_COL; c++) begin
			ext = {{(`QDQ_ELEM_W - `QDQ_Q_W){i_rd_word.elem[c][`QDQ_Q_W-1]}},
				i_rd_word.elem[c]};
			deq.elem[c] = ext << i_rd_word.shift;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			rq_q <= i_rq;
		end
		if (i_rd_valid) begin
			o_out_row <= deq;
		end
	end

	always_ff @(posedge clk or negedge rstnn) begin
		if (!rstnn) begin
			o_out_valid <= 1'b0;
		end else begin
			o_out_valid <= i_rd_valid;
		end
	end

	// consumer never hands back more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!rstnn)
		i_out_credit |-> (credit_cnt < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// File: hw/qdq_top.sv
`timescale 1ns/100ps
`default_nettype none

module qdq_top
	import qdq_pkg::*;
(
	input wire clk,
	input wire rstnn,

	input wire i_x_valid,
	input wire qdq_in_row_t i_x_row,
	output logic o_x_credit,

	input wire i_w_valid,
	input wire qdq_in_row_t i_w_row,
	output logic o_w_credit,

	input wire i_rq_valid,
	input wire qdq_rd_req_t i_rq,
	output logic o_rq_credit,

	output logic o_out_valid,
	output qdq_out_row_t o_out_row,
	input wire i_out_credit,

	output logic [1:0] o_stored
);

	logic x_f_valid;
	logic x_f_ready;
	qdq_in_row_t x_f_row;
	logic w_f_valid;
	logic w_f_ready;
	qdq_in_row_t w_f_row;

	logic x_q_valid;
	logic x_q_ready;
	qdq_q_row_t x_q_row;
	logic w_q_valid;
	logic w_q_ready;
	qdq_q_row_t w_q_row;

	logic wr_en;
	qdq_sram_wr_t wr;

	logic rq_f_valid;
	logic rq_f_ready;
	qdq_rd_req_t rq_f;
	logic rd_en;
	qdq_word_idx_t rd_idx;
	logic rd_valid;
	qdq_q_word_t rd_word;

	// ----------------------------------------
	// store path
	// ----------------------------------------

	qdq_row_fifo #(.T(qdq_in_row_t)) u_x_fifo (
		.clk(clk), .rstnn(rstnn),
		.i_valid(i_x_valid), .i_data(i_x_row), .o_credit(o_x_credit),
		.o_valid(x_f_valid), .o_data(x_f_row), .i_ready(x_f_ready)
	);

	qdq_row_fifo #(.T(qdq_in_row_t)) u_w_fifo (
		.clk(clk), .rstnn(rstnn),
		.i_valid(i_w_valid), .i_data(i_w_row), .o_credit(o_w_credit),
		.o_valid(w_f_valid), .o_data(w_f_row), .i_ready(w_f_ready)
	);

	qdq_row_quantizer #(.MAT(MAT_X)) u_x_quant (
		.clk(clk), .rstnn(rstnn),
		.i_valid(x_f_valid), .i_row(x_f_row), .o_ready(x_f_ready),
		.o_valid(x_q_valid), .o_row(x_q_row), .i_ready(x_q_ready)
	);

	qdq_row_quantizer #(.MAT(MAT_W)) u_w_quant (
		.clk(clk), .rstnn(rstnn),
		.i_valid(w_f_valid), .i_row(w_f_row), .o_ready(w_f_ready),
		.o_valid(w_q_valid), .o_row(w_q_row), .i_ready(w_q_ready)
	);

	qdq_store_arbiter u_arbiter (
		.clk(clk), .rstnn(rstnn),
		.i_x_valid(x_q_valid), .i_x_row(x_q_row), .o_x_ready(x_q_ready),
		.i_w_valid(w_q_valid), .i_w_row(w_q_row), .o_w_ready(w_q_ready),
		.o_wr_en(wr_en), .o_wr(wr), .o_stored(o_stored)
	);

	qdq_row_sram u_sram (
		.clk(clk), .rstnn(rstnn),
		.i_wr_en(wr_en), .i_wr(wr),
		.i_rd_en(rd_en), .i_rd_idx(rd_idx),
		.o_rd_valid(rd_valid), .o_rd_word(rd_word)
	);

	// ----------------------------------------
	// read path
	// ----------------------------------------

	qdq_row_fifo #(.T(qdq_rd_req_t)) u_rq_fifo (
		.clk(clk), .rstnn(rstnn),
		.i_valid(i_rq_valid), .i_data(i_rq), .o_credit(o_rq_credit),
		.o_valid(rq_f_valid), .o_data(rq_f), .i_ready(rq_f_ready)
	);

	qdq_row_dequantizer u_dequant (
		.clk(clk), .rstnn(rstnn),
		.i_rq_valid(rq_f_valid), .i_rq(rq_f), .o_rq_ready(rq_f_ready),
		.o_rd_en(rd_en), .o_rd_idx(rd_idx),
		.i_rd_valid(rd_valid), .i_rd_word(rd_word),
		.i_out_credit(i_out_credit), .o_out_valid(o_out_valid), .o_out_row(o_out_row)
	);

endmodule

`default_nettype wire

// File: bench/qdq_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "qdq_defines.svh"

module qdq_tb
	import qdq_pkg::*;
();

	localparam int DEPTH = `QDQ_FIFO_DEPTH;
	localparam int NROW = `QDQ_NUM_ROW;
	// two store batches, three read batches
	localparam int TOTAL_ROWS = 72;
	localparam int CYCLE_LIMIT = TOTAL_ROWS * 30 + 200;

	typedef logic [`QDQ_NUM_COL-1:0][`QDQ_ELEM_W-1:0] elems_t;

	logic clk;
	logic rstnn;
	logic i_x_valid;
	qdq_in_row_t i_x_row;
	logic o_x_credit;
	logic i_w_valid;
	qdq_in_row_t i_w_row;
	logic o_w_credit;
	logic i_rq_valid;
	qdq_rd_req_t i_rq;
	logic o_rq_credit;
	logic o_out_valid;
	qdq_out_row_t o_out_row;
	logic i_out_credit;
	logic [1:0] o_stored;

	logic [31:0] lfsr;
	elems_t orig [2][NROW];
	qdq_out_row_t exp_q [$];
	int x_credits, w_credits, rq_credits;
	int x_sent, w_sent, rq_sent;
	int x_ret, w_ret, rq_ret;
	int out_seen, out_ret, pending_ret;
	int stored_cnt [2];
	bit hold_credit;
	int value_errors, other_errors;
	int cycle_cnt;

	qdq_top UUT (
		.clk(clk), .rstnn(rstnn),
		.i_x_valid(i_x_valid), .i_x_row(i_x_row), .o_x_credit(o_x_credit),
		.i_w_valid(i_w_valid), .i_w_row(i_w_row), .o_w_credit(o_w_credit),
		.i_rq_valid(i_rq_valid), .i_rq(i_rq), .o_rq_credit(o_rq_credit),
		.o_out_valid(o_out_valid), .o_out_row(o_out_row), .i_out_credit(i_out_credit),
		.o_stored(o_stored)
	);

	// ----------------------------------------
	// random data and reference model
	// ----------------------------------------

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	// n random bits, sign extended
	function automatic logic [`QDQ_ELEM_W-1:0] rand_elem(input int n);
		int v;
		v = rand_bits(n);
		if (v >= (1 << (n - 1)))
			v = v - (1 << n);
		return v[`QDQ_ELEM_W-1:0];
	endfunction

	function automatic bit row_fits(input elems_t e, input int s);
		int v;
		bit fits;
		fits = 1'b1;
		for (int c = 0; c < `QDQ_NUM_COL; c++) begin
			v = int'($signed(e[c])) >>> s;
			if (v > 127 || v < -128)
				fits = 1'b0;
		end
		return fits;
	endfunction

	// smallest fitting shift, truncate to 8 bits, then scale back
	function automatic elems_t ref_qdq(input elems_t e);
		elems_t r;
		int s;
		int v;
		logic [`QDQ_Q_W-1:0] q;
		s = 0;
		while (!row_fits(e, s))
			s++;
		for (int c = 0; c < `QDQ_NUM_COL; c++) begin
			v = int'($signed(e[c])) >>> s;
			q = v[`QDQ_Q_W-1:0];
			v = int'($signed(q)) << s;
			r[c] = v[`QDQ_ELEM_W-1:0];
		end
		return r;
	endfunction

	task automatic gen_rows(input int m);
		int w;
		for (int r = 0; r < NROW; r++) begin
			for (int c = 0; c < `QDQ_NUM_COL; c++) begin
				// row 0 fits without a shift
				if (r == 0)
					w = 7;
				else
					w = 4 + rand_bits(4) % 13;
				orig[m][r][c] = rand_elem(w);
			end
		end
		// most negative value needs the full shift of 8
		orig[m][1][0] = 16'h8000;
	endtask

	// ----------------------------------------
	// stimulus and checks
	// ----------------------------------------

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		value_errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		other_errors++;
	endtask

	task automatic send_row(input int m, input int idx);
		qdq_in_row_t row;
		row.elem = orig[m][idx];
		row.last = (idx == NROW - 1);
		row.row_idx = qdq_row_idx_t'(idx);
		if (m == 0) begin
			while (x_credits == 0) begin
				@(posedge clk);
				#2;
			end
			i_x_valid = 1'b1;
			i_x_row = row;
			x_credits--;
			x_sent++;
			@(posedge clk);
			#2;
			i_x_valid = 1'b0;
		end else begin
			while (w_credits == 0) begin
				@(posedge clk);
				#2;
			end
			i_w_valid = 1'b1;
			i_w_row = row;
			w_credits--;
			w_sent++;
			@(posedge clk);
			#2;
			i_w_valid = 1'b0;
		end
	endtask

	task automatic send_req(input int m, input int idx);
		qdq_out_row_t e;
		while (rq_credits == 0) begin
			@(posedge clk);
			#2;
		end
		i_rq_valid = 1'b1;
		i_rq.mat = qdq_mat_e'(m);
		i_rq.row_idx = qdq_row_idx_t'(idx);
		rq_credits--;
		rq_sent++;
		e.elem = ref_qdq(orig[m][idx]);
		e.mat = qdq_mat_e'(m);
		e.row_idx = qdq_row_idx_t'(idx);
		exp_q.push_back(e);
		@(posedge clk);
		#2;
		i_rq_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || pending_ret != 0)
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#10;
			clk = ~clk;
		end
	end

	// consumer hands back one credit per row received
	initial begin : out_credit_driver
		forever begin
			@(posedge clk);
			#2;
			i_out_credit = 1'b0;
			if (!hold_credit && pending_ret > 0) begin
				i_out_credit = 1'b1;
				pending_ret--;
				out_ret++;
			end
		end
	end

	always @(negedge clk) begin : monitor
		qdq_out_row_t e;
		if (rstnn) begin
			if (o_x_credit) begin
				x_credits++;
				x_ret++;
			end
			if (o_w_credit) begin
				w_credits++;
				w_ret++;
			end
			if (o_rq_credit) begin
				rq_credits++;
				rq_ret++;
			end
			if (o_stored[0])
				stored_cnt[0]++;
			if (o_stored[1])
				stored_cnt[1]++;
			if (o_out_valid) begin
				out_seen++;
				pending_ret++;
				if (out_seen - out_ret > DEPTH)
					note_failure("output row sent without an output credit");
				if (exp_q.size() == 0) begin
					note_failure("output row arrived with no request pending");
				end else begin
					e = exp_q.pop_front();
					if (o_out_row.mat !== e.mat)
						report_mismatch("o_out_row.mat", o_out_row.mat, e.mat);
					if (o_out_row.row_idx !== e.row_idx)
						report_mismatch("o_out_row.row_idx", o_out_row.row_idx, e.row_idx);
					for (int c = 0; c < `QDQ_NUM_COL; c++) begin
						if (o_out_row.elem[c] !== e.elem[c])
							report_mismatch($sformatf("o_out_row.elem[%0d]", c),
								o_out_row.elem[c], e.elem[c]);
					end
				end
			end
		end
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : main
		int out_base;
		int rq_base;
		lfsr = 32'h42dc_572f;
		rstnn = 1'b0;
		i_x_valid = 1'b0;
		i_x_row = '0;
		i_w_valid = 1'b0;
		i_w_row = '0;
		i_rq_valid = 1'b0;
		i_rq = '0;
		i_out_credit = 1'b0;
		hold_credit = 1'b0;
		x_credits = DEPTH;
		w_credits = DEPTH;
		rq_credits = DEPTH;
		repeat (16) @(posedge clk);
		#2;
		rstnn = 1'b1;
		@(posedge clk);
		#2;

		// both matrices, one after the other
		gen_rows(0);
		gen_rows(1);
		for (int i = 0; i < NROW; i++)
			send_row(0, i);
		for (int i = 0; i < NROW; i++)
			send_row(1, i);
		while (stored_cnt[0] < 1 || stored_cnt[1] < 1)
			@(negedge clk);
		repeat (10) @(negedge clk);
		if (stored_cnt[0] != 1 || stored_cnt[1] != 1)
			note_failure("o_stored did not pulse exactly once per matrix");

		// read back all rows, matrices mixed
		@(posedge clk);
		#2;
		for (int i = 0; i < NROW; i++) begin
			send_req(0, i);
			send_req(1, NROW - 1 - i);
		end
		wait_drain();

		// output credits withheld
		hold_credit = 1'b1;
		out_base = out_seen;
		for (int i = 0; i < NROW; i++)
			send_req(1, i);
		rq_base = rq_ret;
		repeat (20) @(negedge clk);
		if (out_seen - out_base > DEPTH)
			note_failure("more output rows than output credits while credits were held");
		if (rq_ret != rq_base || rq_credits != 0)
			note_failure("request credits kept returning with the output stalled");
		hold_credit = 1'b0;
		wait_drain();

		// new data, X and W alternating cycle by cycle
		gen_rows(0);
		gen_rows(1);
		fork
			begin
				for (int i = 0; i < NROW; i++) begin
					send_row(0, i);
					@(posedge clk);
					#2;
				end
			end
			begin
				@(posedge clk);
				#2;
				for (int i = 0; i < NROW; i++) begin
					send_row(1, i);
					@(posedge clk);
					#2;
				end
			end
		join
		while (stored_cnt[0] < 2 || stored_cnt[1] < 2)
			@(negedge clk);
		@(posedge clk);
		#2;
		for (int i = 0; i < NROW; i++) begin
			send_req(1, i);
			send_req(0, i);
		end
		wait_drain();
		repeat (10) @(negedge clk);

		if (stored_cnt[0] != 2 || stored_cnt[1] != 2)
			note_failure("o_stored pulse count wrong after the second batch");
		if (x_ret != x_sent)
			note_failure("o_x_credit pulses differ from X rows sent");
		if (w_ret != w_sent)
			note_failure("o_w_credit pulses differ from W rows sent");
		if (rq_ret != rq_sent)
			note_failure("o_rq_credit pulses differ from requests sent");
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/qdq_pkg.sv
hw/qdq_row_fifo.sv
hw/qdq_row_quantizer.sv
hw/qdq_store_arbiter.sv
hw/qdq_row_sram.sv
hw/qdq_row_dequantizer.sv
hw/qdq_top.sv
bench/qdq_tb.sv
